/* rtl/rv_pkg.sv */
// rv_pkg: widths, rv32i opcode/funct encodings, alu operations and instruction formats
package rv_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int unsigned xlen   = 32;  // data path width
  localparam int unsigned gpr_aw = 5;   // 32 gprs, 4 would be rv32e

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  localparam logic [6:0] op_reg = 7'b0110011;  // OP, reg-reg
  localparam logic [6:0] op_imm = 7'b0010011;  // OP-IMM, reg-imm

  localparam logic [2:0] f3_add  = 3'b000;  // add/sub/addi
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;  // srl/sra, picked by funct7[5]
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // alu operation select
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or,  alu_and
  } alu_op_e;

  // one instruction word, two views
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;  // sign bit in [11]
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
  } instr_t;

endpackage : rv_pkg

/* rtl/rv_alu.sv */
// rv_alu: rv32i integer alu, arithmetic, logic, compares and shifts
`timescale 1ns/1ps

module rv_alu (
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  input  rv_pkg::alu_op_e         alu_op,
  output logic [rv_pkg::xlen-1:0] y
);

  import rv_pkg::*;

  logic [4:0] shamt;  // low 5 bits only
  logic       lt_s;   // signed a < b
  logic       lt_u;   // unsigned a < b

  ////////////////////////////////////////
  // shared terms
  ////////////////////////////////////////

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  ////////////////////////////////////////
  // result mux
  ////////////////////////////////////////

  always_comb begin
    case (alu_op)
      alu_add:  y = a + b;
      alu_sub:  y = a - b;
      alu_sll:  y = a << shamt;
      alu_slt:  y = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: y = {{(xlen-1){1'b0}}, lt_u};
      alu_xor:  y = a ^ b;
      alu_srl:  y = a >> shamt;
      alu_sra:  y = $signed(a) >>> shamt;  // sign fill
      alu_or:   y = a | b;
      alu_and:  y = a & b;
      default:  y = '0;  // unused encodings
    endcase
  end

endmodule : rv_alu

/* rtl/rv_decode.sv */
// rv_decode: splits an OP/OP-IMM word into regs, immediate, alu op and legality
`timescale 1ns/1ps

module rv_decode (
  input  rv_pkg::instr_t            instr,
  output logic [rv_pkg::gpr_aw-1:0] rs1,
  output logic [rv_pkg::gpr_aw-1:0] rs2,
  output logic [rv_pkg::gpr_aw-1:0] rd,
  output logic                      use_imm,  // operand b from imm
  output logic [rv_pkg::xlen-1:0]   imm,
  output rv_pkg::alu_op_e           alu_op,
  output logic                      legal
);

  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;   // imm[11:5] on OP-IMM
  logic       f7_base;  // 0000000
  logic       f7_alt;   // 0100000
  logic       sub_sel;  // sub only exists on OP

  ////////////////////////////////////////
  // fields
  ////////////////////////////////////////

  assign opcode = instr.r_fmt.opcode;
  assign funct3 = instr.r_fmt.funct3;
  assign funct7 = instr.r_fmt.funct7;

  assign rs1 = instr.r_fmt.rs1;
  assign rs2 = instr.r_fmt.rs2;  // don't care on OP-IMM
  assign rd  = instr.r_fmt.rd;

  // i-type immediate, sign extended
  assign imm     = {{(xlen-12){instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
  assign use_imm = (opcode == op_imm);

  assign f7_base = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);
  assign sub_sel = (opcode == op_reg) & f7_alt;

  ////////////////////////////////////////
  // alu op
  ////////////////////////////////////////

  always_comb begin
    alu_op = alu_add;
    case (funct3)
      f3_add:  alu_op = sub_sel ? alu_sub : alu_add;
      f3_sll:  alu_op = alu_sll;
      f3_slt:  alu_op = alu_slt;
      f3_sltu: alu_op = alu_sltu;
      f3_xor:  alu_op = alu_xor;
      f3_sr:   alu_op = f7_alt ? alu_sra : alu_srl;  // same bit on both formats
      f3_or:   alu_op = alu_or;
      f3_and:  alu_op = alu_and;
    endcase
  end

  // legality
  always_comb begin
    case (opcode)
      op_reg: legal = f7_base | f7_alt;
      op_imm: begin
        case (funct3)
          f3_sll:  legal = f7_base;           // slli, upper imm must be zero
          f3_sr:   legal = f7_base | f7_alt;  // srli / srai
          default: legal = 1'b1;              // plain immediate ops
        endcase
      end
      default: legal = 1'b0;  // not handled by this slice
    endcase
  end

endmodule : rv_decode

/* rtl/rv_gpr.sv */
// rv_gpr: 32 entry register file, two async read ports, one write port with bypass
`timescale 1ns/1ps

module rv_gpr (
  input  logic                      clk,
  // write port, from write-back stage
  input  logic                      we,
  input  logic [rv_pkg::gpr_aw-1:0] waddr,
  input  logic [rv_pkg::xlen-1:0]   wdata,
  // read addresses
  input  logic [rv_pkg::gpr_aw-1:0] raddr1,
  input  logic [rv_pkg::gpr_aw-1:0] raddr2,
  // read data, already bypassed
  output logic [rv_pkg::xlen-1:0]   rdata1,
  output logic [rv_pkg::xlen-1:0]   rdata2
);

  import rv_pkg::*;

  logic            wen;       // qualified write enable
  logic            byp1;      // port 1 hits pending write
  logic            byp2;      // port 2 hits pending write
  logic [xlen-1:0] mem_rd1;   // raw array reads
  logic [xlen-1:0] mem_rd2;

  // inferred array, starts all zero
  logic [xlen-1:0] mem [0:2**gpr_aw-1] = '{default: '0};

  ////////////////////////////////////////
  // write
  ////////////////////////////////////////

  assign wen = we & (|waddr);  // x0 never stored

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  ////////////////////////////////////////
  // read + bypass
  ////////////////////////////////////////

  assign mem_rd1 = mem[raddr1];
  assign mem_rd2 = mem[raddr2];

  // wen already excludes x0, so a hit means nonzero address
  assign byp1 = wen & (waddr == raddr1);
  assign byp2 = wen & (waddr == raddr2);

  assign rdata1 = (raddr1 == '0) ? '0 :     // x0 hard zero
                  byp1           ? wdata :  // same-cycle write
                                   mem_rd1;
  assign rdata2 = (raddr2 == '0) ? '0 :
                  byp2           ? wdata :
                                   mem_rd2;

endmodule : rv_gpr

/* rtl/rv_exec_core.sv */
// rv_exec_core: register read, execute and write-back slice for rv32i alu instructions
`timescale 1ns/1ps

module rv_exec_core (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      instr_valid,  // one strobe per instruction
  input  rv_pkg::instr_t            instr,
  output logic                      wb_valid,
  output logic [rv_pkg::gpr_aw-1:0] wb_rd,
  output logic [rv_pkg::xlen-1:0]   wb_data,
  output logic                      illegal       // one cycle pulse
);

  import rv_pkg::*;

  logic [gpr_aw-1:0] rs1;
  logic [gpr_aw-1:0] rs2;
  logic [gpr_aw-1:0] rd;
  logic              use_imm;
  logic [xlen-1:0]   imm;
  alu_op_e           alu_op;
  logic              legal;
  logic [xlen-1:0]   rdata1;   // bypassed operands
  logic [xlen-1:0]   rdata2;
  logic [xlen-1:0]   alu_b;
  logic [xlen-1:0]   alu_y;

  ////////////////////////////////////////
  // decode, read, execute
  ////////////////////////////////////////

  rv_decode u_decode (
    .instr   (instr),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .use_imm (use_imm),
    .imm     (imm),
    .alu_op  (alu_op),
    .legal   (legal)
  );

  // write port fed back from wb stage
  rv_gpr u_gpr (
    .clk    (clk),
    .we     (wb_valid),
    .waddr  (wb_rd),
    .wdata  (wb_data),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  assign alu_b = use_imm ? imm : rdata2;  // OP-IMM takes the immediate

  rv_alu u_alu (
    .a      (rdata1),
    .b      (alu_b),
    .alu_op (alu_op),
    .y      (alu_y)
  );

  ////////////////////////////////////////
  // write-back stage
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      wb_valid <= instr_valid & legal;
      illegal  <= instr_valid & ~legal;  // no write, just flag it
    end
  end

  // payload, held until next legal instruction
  always_ff @(posedge clk) begin
    if (instr_valid && legal) begin
      wb_rd   <= rd;
      wb_data <= alu_y;
    end
  end

endmodule : rv_exec_core

/* tests/rv_exec_core_tb.sv */
// rv_exec_core_tb: table-driven testbench for the rv32i execute slice with a register model
`timescale 1ns/1ps

module rv_exec_core_tb;

  import rv_pkg::*;

  logic              clk;
  logic              rst;
  logic              instr_valid;
  instr_t            instr;
  logic              wb_valid;
  logic [gpr_aw-1:0] wb_rd;
  logic [xlen-1:0]   wb_data;
  logic              illegal;

  // stimulus table with one entry per cycle
  logic [31:0] q_instr [$];
  logic        q_valid [$];   // 0 marks an idle gap
  logic [4:0]  q_rd    [$];
  logic [31:0] q_data  [$];
  logic        q_ill   [$];

  logic [31:0] ref_regs [32];  // architectural state with x0 never written
  logic [31:0] rng_state;
  int          n_entries;
  logic        table_ready;

  rv_exec_core uut (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .illegal     (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // rv32i alu semantics with alt as funct7 bit 5
  function automatic logic [31:0] ref_alu(input logic [31:0] a, input logic [31:0] b,
                                          input logic [2:0] f3, input logic alt);
    logic [31:0] y;
    case (f3)
      f3_add:  y = alt ? a - b : a + b;
      f3_sll:  y = a << b[4:0];
      f3_slt:  y = {31'b0, $signed(a) < $signed(b)};
      f3_sltu: y = {31'b0, a < b};
      f3_xor:  y = a ^ b;
      f3_sr: begin
        if (alt)
          y = $signed(a) >>> b[4:0];  // sign fill
        else
          y = a >> b[4:0];
      end
      f3_or:   y = a | b;
      default: y = a & b;
    endcase
    return y;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, op_imm};
  endfunction

  // decode by bit slices, predict, update reference regs, append entry
  task automatic issue(input logic [31:0] word);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [31:0] b;
    logic        ok;
    logic        alt;
    logic [31:0] res;
    opc = word[6:0];
    rd  = word[11:7];
    f3  = word[14:12];
    rs1 = word[19:15];
    f7  = word[31:25];
    alt = (f7 == 7'b0100000);
    b   = {{20{word[31]}}, word[31:20]};  // i-type immediate
    ok  = 1'b0;
    if (opc == op_reg) begin
      ok = (f7 == 7'b0) || alt;
      b  = ref_regs[word[24:20]];
    end else if (opc == op_imm) begin
      if (f3 == f3_sll)
        ok = (f7 == 7'b0);
      else if (f3 == f3_sr)
        ok = (f7 == 7'b0) || alt;
      else begin
        ok  = 1'b1;
        alt = 1'b0;  // no subi
      end
    end
    res = ref_alu(ref_regs[rs1], b, f3, alt);
    if (ok && rd != 5'd0)
      ref_regs[rd] = res;
    q_instr.push_back(word);
    q_valid.push_back(1'b1);
    q_rd.push_back(rd);
    q_data.push_back(res);
    q_ill.push_back(~ok);
  endtask

  // strobe low so the word on the bus is ignored
  task automatic idle_gap(input logic [31:0] word = 32'h0);
    q_instr.push_back(word);
    q_valid.push_back(1'b0);
    q_rd.push_back(5'd0);
    q_data.push_back(32'h0);
    q_ill.push_back(1'b0);
  endtask

  // wide random value built by addi from x0, slli and xori
  task automatic load_random(input logic [4:0] rd);
    logic [31:0] r;
    rng_state = xorshift32(rng_state);
    r = rng_state;
    issue(i_type(r[11:0], 5'd0, f3_add, rd));
    issue(i_type({7'b0, r[16:12]}, rd, f3_sll, rd));
    issue(i_type(r[28:17], rd, f3_xor, rd));
  endtask

  ////////////////////////////////////////
  // test table
  ////////////////////////////////////////

  task automatic build_table();
    logic [4:0] d;
    logic [4:0] pa [3];
    logic [4:0] pb [3];
    pa = '{5'd17, 5'd18, 5'd16};
    pb = '{5'd16, 5'd1, 5'd17};
    repeat (3) idle_gap();  // quiet after reset
    for (int r = 0; r < 32; r++) begin
      issue(r_type(7'd0, 5'd0, 5'(r), f3_add, 5'(r)));  // add xr, xr, x0 reads zero
    end
    // op-imm on random sources with negative immediates
    load_random(5'd1);
    load_random(5'd2);
    issue(i_type(12'hffb, 5'd1, f3_add, 5'd3));   // addi -5
    issue(i_type(12'hfff, 5'd1, f3_slt, 5'd4));   // slti -1
    issue(i_type(12'h7ff, 5'd2, f3_slt, 5'd5));
    issue(i_type(12'hfff, 5'd1, f3_sltu, 5'd6));  // compares with 0xffffffff
    issue(i_type(12'h123, 5'd2, f3_sltu, 5'd7));
    issue(i_type(12'h800, 5'd1, f3_xor, 5'd8));
    issue(i_type(12'hf0f, 5'd2, f3_or, 5'd9));
    issue(i_type(12'h8f3, 5'd1, f3_and, 5'd10));
    issue(i_type(12'h007, 5'd1, f3_sll, 5'd11));
    issue(i_type(12'h01f, 5'd2, f3_sr, 5'd12));   // srli 31
    issue(i_type(12'h409, 5'd1, f3_sr, 5'd13));   // srai 9
    // boundary operands
    issue(i_type(12'hfff, 5'd0, f3_add, 5'd16));   // 0xffffffff
    issue(i_type(12'h001, 5'd0, f3_add, 5'd17));
    issue(i_type(12'h01f, 5'd17, f3_sll, 5'd17));  // 0x80000000
    issue(i_type(12'h404, 5'd17, f3_sr, 5'd14));   // srai on negative
    load_random(5'd18);
    // all reg-reg ops on three operand pairs
    d = 5'd20;
    for (int p = 0; p < 3; p++) begin
      for (int f = 0; f < 10; f++) begin
        if (f < 8)
          issue(r_type(7'h00, pb[p], pa[p], 3'(f), d));
        else
          issue(r_type(7'h20, pb[p], pa[p], (f == 8) ? f3_add : f3_sr, d));  // sub, sra
        d = (d == 5'd29) ? 5'd20 : d + 5'd1;
      end
    end
    // dependent chains through the bypass
    issue(i_type(12'h055, 5'd0, f3_add, 5'd5));
    issue(i_type(12'h001, 5'd5, f3_add, 5'd5));
    issue(r_type(7'h00, 5'd5, 5'd5, f3_add, 5'd6));  // both ports bypassed
    issue(r_type(7'h20, 5'd5, 5'd6, f3_add, 5'd7));  // rs2 from array
    idle_gap();
    issue(r_type(7'h00, 5'd6, 5'd7, f3_xor, 5'd8));  // stored values only
    // x0 as destination
    issue(i_type(12'h123, 5'd1, f3_add, 5'd0));
    issue(r_type(7'h00, 5'd0, 5'd0, f3_or, 5'd9));   // must not bypass x0
    issue(r_type(7'h00, 5'd1, 5'd0, f3_add, 5'd10));
    // illegal words
    issue({12'h000, 5'd2, 3'b010, 5'd1, 7'b0000011});  // lw opcode is not handled here
    idle_gap();                                         // pulse is one cycle
    issue(r_type(7'h01, 5'd2, 5'd1, f3_add, 5'd3));    // mul encoding
    issue(i_type(12'h603, 5'd1, f3_sr, 5'd1));         // srai with upper imm 0110000
    issue(i_type(12'h403, 5'd1, f3_sll, 5'd2));
    idle_gap(i_type(12'h3ff, 5'd0, f3_add, 5'd3));     // legal addi without strobe
    issue(r_type(7'h00, 5'd0, 5'd1, f3_add, 5'd20));   // regs untouched
    issue(r_type(7'h00, 5'd0, 5'd3, f3_add, 5'd21));
    issue(r_type(7'h00, 5'd2, 5'd0, f3_add, 5'd22));
    repeat (2) idle_gap();
  endtask

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic value_error(input string name, input int k,
                             input logic [31:0] exp, input logic [31:0] act);
    $display("** Error at %0t: entry %0d, %s expected 0x%08h, got 0x%08h",
             $time, k, name, exp, act);
    $display("Simulation FAILED");
    $fatal(1, "mismatch on %s", name);
  endtask

  task automatic check_entry(input int k);
    logic exp_wb;
    exp_wb = q_valid[k] & ~q_ill[k];
    assert (wb_valid === exp_wb)
      else value_error("wb_valid", k, 32'(exp_wb), 32'(wb_valid));
    assert (illegal === q_ill[k])
      else value_error("illegal", k, 32'(q_ill[k]), 32'(illegal));
    if (exp_wb) begin  // payload only meaningful on a retire
      assert (wb_rd === q_rd[k])
        else value_error("wb_rd", k, 32'(q_rd[k]), 32'(wb_rd));
      assert (wb_data === q_data[k])
        else value_error("wb_data", k, q_data[k], wb_data);
    end
  endtask

  // watchdog
  initial begin
    wait (table_ready);
    #((n_entries + 20) * 10);
    $display("timeout: the table did not finish within %0d cycles", n_entries + 20);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    table_ready = 1'b0;
    rng_state   = 32'hebe8;
    for (int k = 0; k < 32; k++) begin
      ref_regs[k] = '0;
    end
    build_table();
    n_entries   = q_instr.size();
    table_ready = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // drive entry i, check entry i-1 a cycle later at the falling edge
    for (int i = 0; i <= n_entries; i++) begin
      @(posedge clk);
      if (i < n_entries) begin
        instr_valid <= q_valid[i];
        instr       <= q_instr[i];
      end else begin
        instr_valid <= 1'b0;
        instr       <= '0;
      end
      @(negedge clk);
      if (i > 0)
        check_entry(i - 1);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule : rv_exec_core_tb

/* rv_exec_core.f */
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_decode.sv
rtl/rv_gpr.sv
rtl/rv_exec_core.sv
tests/rv_exec_core_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module rv_exec_core_tb -f rv_exec_core.f -o rv_exec_core_sim &&
./obj_dir/rv_exec_core_sim | tee /dev/stderr | grep -q "^Simulation PASSED$" &&
echo "run.sh: pass" ||
{ echo "run.sh: fail"; exit 1; }
